/* common/dma_mem_pkg.sv */
package dma_mem_pkg;

  // Beat width of the stream and of one scratchpad line
  localparam int DEF_DATA_WIDTH = 64;

  // Byte address width, 4 KB of scratchpad
  localparam int DEF_ADDR_WIDTH = 12;

  // Byte length width of a descriptor
  localparam int DEF_LEN_WIDTH  = 10;

  // Output FIFO depth, covers the issue to pop round trip at full rate
  localparam int DEF_FIFO_LINES = 8;

  // Even lines in bank 1, odd lines in bank 2
  localparam int NUM_BANKS      = 2;

endpackage

/* common/dma_ctrl_pkg.sv */
package dma_ctrl_pkg;

  // Issuer FSM
  typedef enum logic [0:0] {
    ISS_IDLE,
    ISS_RUN
  } issuer_state_e;

  // Cycles from a bank enable to valid bank data
  localparam int MEM_RD_LATENCY = 2;

  // Line metadata leaves the issuer together with the bank enables,
  // so it needs one delay stage per memory cycle
  localparam int ALIGN_STAGES   = MEM_RD_LATENCY;

endpackage

/* common/bank_rd_if.sv */
interface bank_rd_if #(
  parameter int DATA_WIDTH     = 64,
  parameter int MEM_ADDR_WIDTH = 8
);

  logic                      b1_en;
  logic [MEM_ADDR_WIDTH-1:0] b1_addr;
  logic [DATA_WIDTH-1:0]     b1_data;

  logic                      b2_en;
  logic [MEM_ADDR_WIDTH-1:0] b2_addr;
  logic [DATA_WIDTH-1:0]     b2_data;

  modport requester (
    output b1_en, b1_addr, b2_en, b2_addr
  );

  modport memory (
    input  b1_en, b1_addr, b2_en, b2_addr,
    output b1_data, b2_data
  );

  modport sink (
    input b1_data, b2_data
  );

endinterface

/* common/line_req_if.sv */
interface line_req_if #(
  parameter int MASK_BITS = 3
);

  logic                 valid;
  logic                 first;
  logic                 last;
  // Bank holding the lower line of the pair
  logic                 bank;
  logic [MASK_BITS-1:0] offset;
  logic [MASK_BITS-1:0] empty;

  modport source (
    output valid, first, last, bank, offset, empty
  );

  modport sink (
    input valid, first, last, bank, offset, empty
  );

endinterface

/* hw/rd_dma/rd_desc_issuer.sv */
module rd_desc_issuer
  import dma_mem_pkg::*, dma_ctrl_pkg::*;
#(
  parameter int ADDR_WIDTH     = 12,
  parameter int LEN_WIDTH      = 10,
  parameter int DATA_WIDTH     = 64,
  parameter int FIFO_LINES     = 8,
  parameter int MEM_ADDR_WIDTH = 8
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic [ADDR_WIDTH-1:0] desc_addr,
  input  logic [LEN_WIDTH-1:0]  desc_len,
  input  logic                  desc_valid,
  input  logic                  accel_stop,
  output logic                  desc_ready,
  input  logic                  pop,
  output logic                  flush,
  bank_rd_if.requester          mem,
  line_req_if.source            req
);

  localparam int KEEP_BYTES   = DATA_WIDTH / 8;
  localparam int MASK_BITS    = $clog2(KEEP_BYTES);
  localparam int BANK_BITS    = $clog2(NUM_BANKS);
  localparam int LINE_WIDTH   = ADDR_WIDTH - MASK_BITS;
  localparam int CNT_WIDTH    = LEN_WIDTH - MASK_BITS + 1;
  localparam int CREDIT_WIDTH = $clog2(FIFO_LINES) + 1;

  issuer_state_e state;

  logic                    stop_r;
  logic [CREDIT_WIDTH-1:0] credit_cnt;

  logic [LINE_WIDTH-1:0] cur_line;
  logic [LINE_WIDTH-1:0] next_line;
  logic [CNT_WIDTH-1:0]  lines_left;
  logic [MASK_BITS-1:0]  offset;
  logic [MASK_BITS-1:0]  final_empty;
  logic                  first_line;

  logic [MASK_BITS-1:0] len_rem;
  logic                 accept;
  logic                 issue;
  logic                 last_line;

  assign len_rem   = desc_len[MASK_BITS-1:0];
  // Wraps past the top of memory
  assign next_line = cur_line + 1'b1;
  assign last_line = (lines_left == CNT_WIDTH'(1));

  assign issue      = (state == ISS_RUN) && !stop_r &&
                      (credit_cnt < CREDIT_WIDTH'(FIFO_LINES));
  assign desc_ready = (state == ISS_IDLE) || (issue && last_line);
  assign accept     = desc_valid && desc_ready;
  assign flush      = stop_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= ISS_IDLE;
      stop_r     <= 1'b0;
      credit_cnt <= '0;
    end else begin
      // Stop holds until the next descriptor is offered
      if (desc_valid) begin
        stop_r <= 1'b0;
      end else if (accel_stop) begin
        stop_r <= 1'b1;
      end

      if (accept) begin
        state <= ISS_RUN;
      end else if (stop_r || (issue && last_line)) begin
        state <= ISS_IDLE;
      end

      if (stop_r) begin
        credit_cnt <= '0;
      end else if (issue && !pop) begin
        credit_cnt <= credit_cnt + 1'b1;
      end else if (pop && !issue) begin
        credit_cnt <= credit_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cur_line    <= desc_addr[ADDR_WIDTH-1:MASK_BITS];
      lines_left  <= CNT_WIDTH'(desc_len[LEN_WIDTH-1:MASK_BITS]) +
                     CNT_WIDTH'(len_rem != '0);
      offset      <= desc_addr[MASK_BITS-1:0];
      // A zero remainder truncates to zero empty bytes
      final_empty <= MASK_BITS'(KEEP_BYTES - len_rem);
      first_line  <= 1'b1;
    end else if (issue) begin
      cur_line   <= next_line;
      lines_left <= lines_left - 1'b1;
      first_line <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mem.b1_en <= 1'b0;
      mem.b2_en <= 1'b0;
      req.valid <= 1'b0;
    end else begin
      mem.b1_en <= issue;
      mem.b2_en <= issue;
      req.valid <= issue;
    end
  end

  // Line L from its own bank, line L+1 from the other one
  always_ff @(posedge clk) begin
    mem.b1_addr <= cur_line[0] ? next_line[MEM_ADDR_WIDTH+BANK_BITS-1:BANK_BITS] :
                                 cur_line[MEM_ADDR_WIDTH+BANK_BITS-1:BANK_BITS];
    mem.b2_addr <= cur_line[0] ? cur_line[MEM_ADDR_WIDTH+BANK_BITS-1:BANK_BITS] :
                                 next_line[MEM_ADDR_WIDTH+BANK_BITS-1:BANK_BITS];
    req.first   <= first_line;
    req.last    <= last_line;
    req.bank    <= cur_line[0];
    req.offset  <= offset;
    req.empty   <= last_line ? final_empty : '0;
  end

endmodule

/* hw/rd_dma/rd_line_aligner.sv */
module rd_line_aligner
  import dma_ctrl_pkg::*;
#(
  parameter int DATA_WIDTH = 64
) (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       flush,
  bank_rd_if.sink                                    mem,
  line_req_if.sink                                   req,
  output logic                                       wr_valid,
  output logic [DATA_WIDTH+$clog2(DATA_WIDTH/8)+1:0] wr_beat
);

  localparam int MASK_BITS  = $clog2(DATA_WIDTH / 8);
  localparam int META_WIDTH = 3 + 2 * MASK_BITS;

  logic                  valid_d [ALIGN_STAGES];
  logic [META_WIDTH-1:0] meta_d  [ALIGN_STAGES];

  logic                 d_first;
  logic                 d_last;
  logic                 d_bank;
  logic [MASK_BITS-1:0] d_offset;
  logic [MASK_BITS-1:0] d_empty;

  logic [2*DATA_WIDTH-1:0] merged;
  logic [2*DATA_WIDTH-1:0] shifted;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      for (int i = 0; i < ALIGN_STAGES; i++) begin
        valid_d[i] <= 1'b0;
      end
    end else begin
      valid_d[0] <= req.valid;
      for (int i = 1; i < ALIGN_STAGES; i++) begin
        valid_d[i] <= valid_d[i-1];
      end
    end
  end

  always_ff @(posedge clk) begin
    meta_d[0] <= {req.first, req.last, req.bank, req.offset, req.empty};
    for (int i = 1; i < ALIGN_STAGES; i++) begin
      meta_d[i] <= meta_d[i-1];
    end
  end

  assign {d_first, d_last, d_bank, d_offset, d_empty} = meta_d[ALIGN_STAGES-1];

  // Lower line in the low half
  assign merged  = d_bank ? {mem.b1_data, mem.b2_data} :
                            {mem.b2_data, mem.b1_data};
  assign shifted = merged >> {d_offset, 3'b000};

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_valid <= 1'b0;
    end else begin
      wr_valid <= valid_d[ALIGN_STAGES-1];
    end
  end

  always_ff @(posedge clk) begin
    wr_beat <= {d_first, d_last, d_empty, shifted[DATA_WIDTH-1:0]};
  end

endmodule

/* hw/rd_dma/rd_out_fifo.sv */
module rd_out_fifo #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             clear,
  input  logic             din_valid,
  input  logic [WIDTH-1:0] din,
  output logic             dout_valid,
  output logic [WIDTH-1:0] dout,
  input  logic             dout_ready
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] buffer [DEPTH];

  logic [PTR_WIDTH-1:0] wr_ptr;
  logic [PTR_WIDTH-1:0] rd_ptr;
  logic [CNT_WIDTH-1:0] count;
  logic [CNT_WIDTH-1:0] count_next;
  logic                 pop;

  function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign pop        = dout_valid && dout_ready;
  assign count_next = count + CNT_WIDTH'(din_valid) - CNT_WIDTH'(pop);

  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      dout_valid <= 1'b0;
    end else begin
      if (din_valid) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      count      <= count_next;
      dout_valid <= (count_next != '0);
    end
  end

  always_ff @(posedge clk) begin
    if (din_valid) begin
      buffer[wr_ptr] <= din;
    end
  end

  // Head entry stays put until popped
  assign dout = buffer[rd_ptr];

endmodule

/* hw/scratch_mem.sv */
module scratch_mem
  import dma_mem_pkg::*, dma_ctrl_pkg::*;
#(
  parameter int DATA_WIDTH = 64,
  parameter int MEM_LINES  = 256
) (
  input  logic                       clk,
  input  logic                       wr_en,
  input  logic [$clog2(MEM_LINES):0] wr_line,
  input  logic [DATA_WIDTH-1:0]      wr_data,
  bank_rd_if.memory                  mem
);

  localparam int BANK_AW = $clog2(MEM_LINES);

  logic                  rd_en   [NUM_BANKS];
  logic [BANK_AW-1:0]    rd_addr [NUM_BANKS];
  logic [DATA_WIDTH-1:0] rd_data [NUM_BANKS];

  // Index 0 is bank 1 with the even lines
  assign rd_en[0]    = mem.b1_en;
  assign rd_addr[0]  = mem.b1_addr;
  assign rd_en[1]    = mem.b2_en;
  assign rd_addr[1]  = mem.b2_addr;
  assign mem.b1_data = rd_data[0];
  assign mem.b2_data = rd_data[1];

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    logic [DATA_WIDTH-1:0] lines    [MEM_LINES];
    logic [DATA_WIDTH-1:0] stage    [MEM_RD_LATENCY];
    logic                  stage_en [MEM_RD_LATENCY-1];

    always_ff @(posedge clk) begin
      if (wr_en && wr_line[0] == 1'(b)) begin
        lines[wr_line[BANK_AW:1]] <= wr_data;
      end
      if (rd_en[b]) begin
        stage[0] <= lines[rd_addr[b]];
      end
    end

    // Output stages only move behind a read, so data holds in between
    always_ff @(posedge clk) begin
      stage_en[0] <= rd_en[b];
      for (int s = 1; s < MEM_RD_LATENCY - 1; s++) begin
        stage_en[s] <= stage_en[s-1];
      end
      for (int s = 1; s < MEM_RD_LATENCY; s++) begin
        if (stage_en[s-1]) begin
          stage[s] <= stage[s-1];
        end
      end
    end

    assign rd_data[b] = stage[MEM_RD_LATENCY-1];
  end

endmodule

/* hw/accel_rd_subsys.sv */
module accel_rd_subsys
  import dma_mem_pkg::*;
#(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter int ADDR_WIDTH = DEF_ADDR_WIDTH,
  parameter int LEN_WIDTH  = DEF_LEN_WIDTH,
  parameter int FIFO_LINES = DEF_FIFO_LINES
) (
  input  logic                                          clk,
  input  logic                                          rst,

  input  logic [ADDR_WIDTH-1:0]                         desc_addr,
  input  logic [LEN_WIDTH-1:0]                          desc_len,
  input  logic                                          desc_valid,
  output logic                                          desc_ready,
  input  logic                                          accel_stop,

  // Scratchpad preload, one full line per write
  input  logic                                          wr_en,
  input  logic [ADDR_WIDTH-$clog2(DATA_WIDTH/8)-1:0]    wr_line,
  input  logic [DATA_WIDTH-1:0]                         wr_data,

  output logic [DATA_WIDTH-1:0]                         m_tdata,
  output logic [$clog2(DATA_WIDTH/8)-1:0]               m_tempty,
  output logic                                          m_tfirst,
  output logic                                          m_tlast,
  output logic                                          m_tvalid,
  input  logic                                          m_tready
);

  localparam int MASK_BITS      = $clog2(DATA_WIDTH / 8);
  localparam int MEM_LINES      = 2 ** (ADDR_WIDTH - MASK_BITS - 1);
  localparam int MEM_ADDR_WIDTH = $clog2(MEM_LINES);
  localparam int BEAT_WIDTH     = DATA_WIDTH + MASK_BITS + 2;

  logic                  pop;
  logic                  flush;
  logic                  wr_valid;
  logic [BEAT_WIDTH-1:0] wr_beat;

  bank_rd_if #(
    .DATA_WIDTH     (DATA_WIDTH),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) bank_rd ();

  line_req_if #(
    .MASK_BITS (MASK_BITS)
  ) line_req ();

  assign pop = m_tvalid && m_tready;

  rd_desc_issuer #(
    .ADDR_WIDTH     (ADDR_WIDTH),
    .LEN_WIDTH      (LEN_WIDTH),
    .DATA_WIDTH     (DATA_WIDTH),
    .FIFO_LINES     (FIFO_LINES),
    .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH)
  ) i_rd_desc_issuer (
    .clk        (clk),
    .rst        (rst),
    .desc_addr  (desc_addr),
    .desc_len   (desc_len),
    .desc_valid (desc_valid),
    .accel_stop (accel_stop),
    .desc_ready (desc_ready),
    .pop        (pop),
    .flush      (flush),
    .mem        (bank_rd.requester),
    .req        (line_req.source)
  );

  scratch_mem #(
    .DATA_WIDTH (DATA_WIDTH),
    .MEM_LINES  (MEM_LINES)
  ) i_scratch_mem (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_line (wr_line),
    .wr_data (wr_data),
    .mem     (bank_rd.memory)
  );

  rd_line_aligner #(
    .DATA_WIDTH (DATA_WIDTH)
  ) i_rd_line_aligner (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .mem      (bank_rd.sink),
    .req      (line_req.sink),
    .wr_valid (wr_valid),
    .wr_beat  (wr_beat)
  );

  rd_out_fifo #(
    .WIDTH (BEAT_WIDTH),
    .DEPTH (FIFO_LINES)
  ) i_rd_out_fifo (
    .clk        (clk),
    .rst        (rst),
    .clear      (flush),
    .din_valid  (wr_valid),
    .din        (wr_beat),
    .dout_valid (m_tvalid),
    .dout       ({m_tfirst, m_tlast, m_tempty, m_tdata}),
    .dout_ready (m_tready)
  );

endmodule

/* tb/accel_rd_checker.sv */
module accel_rd_checker
  import dma_mem_pkg::*, dma_ctrl_pkg::*;
#(
  parameter int DATA_WIDTH = DEF_DATA_WIDTH,
  parameter int FIFO_LINES = DEF_FIFO_LINES
) (
  input logic                              clk,
  input logic                              rst,
  input logic                              flush,
  input logic                              accel_stop,
  input logic                              desc_valid,
  input logic                              desc_ready,
  input logic [DATA_WIDTH-1:0]             m_tdata,
  input logic [$clog2(DATA_WIDTH/8)-1:0]   m_tempty,
  input logic                              m_tfirst,
  input logic                              m_tlast,
  input logic                              m_tvalid,
  input logic                              m_tready,
  input issuer_state_e                     state,
  input logic [$clog2(FIFO_LINES):0]       credit_cnt
);

  timeunit 1ns;
  timeprecision 1ps;

  // Issue, memory latency, aligner register, FIFO output register
  localparam int FIRST_BEAT_LAT = ALIGN_STAGES + 3;

  int fail_cnt = 0;

  // Stop drops the stream without a handshake
  hold_until_handshake: assert property (@(posedge clk) disable iff (rst || flush)
    m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tempty) &&
                              $stable(m_tfirst) && $stable(m_tlast))
  else begin
    $error("stream beat changed or dropped before its handshake");
    fail_cnt++;
  end

  valid_low_after_reset: assert property (@(posedge clk) rst |=> !m_tvalid)
  else begin
    $error("m_tvalid high after reset");
    fail_cnt++;
  end

  credit_bound: assert property (@(posedge clk) disable iff (rst)
    credit_cnt <= FIFO_LINES)
  else begin
    $error("credit count above FIFO depth");
    fail_cnt++;
  end

  first_beat_latency: assert property (@(posedge clk) disable iff (rst || accel_stop)
    desc_valid && desc_ready && state == ISS_IDLE && credit_cnt == '0 && !m_tvalid
    |=> !m_tvalid [*FIRST_BEAT_LAT] ##1 m_tvalid)
  else begin
    $error("first beat not exactly %0d cycles after acceptance", FIRST_BEAT_LAT);
    fail_cnt++;
  end

endmodule

bind accel_rd_subsys accel_rd_checker #(
  .DATA_WIDTH (DATA_WIDTH),
  .FIFO_LINES (FIFO_LINES)
) i_accel_rd_checker (
  .clk        (clk),
  .rst        (rst),
  .flush      (flush),
  .accel_stop (accel_stop),
  .desc_valid (desc_valid),
  .desc_ready (desc_ready),
  .m_tdata    (m_tdata),
  .m_tempty   (m_tempty),
  .m_tfirst   (m_tfirst),
  .m_tlast    (m_tlast),
  .m_tvalid   (m_tvalid),
  .m_tready   (m_tready),
  .state      (i_rd_desc_issuer.state),
  .credit_cnt (i_rd_desc_issuer.credit_cnt)
);

/* tb/accel_rd_subsys_tb.sv */
module accel_rd_subsys_tb
  import dma_mem_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DATA_WIDTH = DEF_DATA_WIDTH;
  localparam int ADDR_WIDTH = DEF_ADDR_WIDTH;
  localparam int LEN_WIDTH  = DEF_LEN_WIDTH;
  localparam int FIFO_LINES = DEF_FIFO_LINES;
  localparam int BYTES      = DATA_WIDTH / 8;
  localparam int MASK_BITS  = $clog2(BYTES);
  localparam int LINE_W     = ADDR_WIDTH - MASK_BITS;
  localparam int LINES      = 2 ** LINE_W;
  localparam int MEM_BYTES  = 2 ** ADDR_WIDTH;
  localparam int BEAT_W     = DATA_WIDTH + MASK_BITS + 2;
  localparam int NUM_DESC   = 29;

  logic                  clk;
  logic                  rst;
  logic [ADDR_WIDTH-1:0] desc_addr;
  logic [LEN_WIDTH-1:0]  desc_len;
  logic                  desc_valid;
  logic                  desc_ready;
  logic                  accel_stop;
  logic                  wr_en;
  logic [LINE_W-1:0]     wr_line;
  logic [DATA_WIDTH-1:0] wr_data;
  logic [DATA_WIDTH-1:0] m_tdata;
  logic [MASK_BITS-1:0]  m_tempty;
  logic                  m_tfirst;
  logic                  m_tlast;
  logic                  m_tvalid;
  logic                  m_tready;

  // Byte image of the scratchpad
  logic [7:0]            mem_model [MEM_BYTES];
  logic [BEAT_W-1:0]     exp_q [$];
  logic [BEAT_W-1:0]     exp_beat;
  logic [ADDR_WIDTH-1:0] d_addr [NUM_DESC];
  logic [LEN_WIDTH-1:0]  d_len [NUM_DESC];

  integer seed = 95052;
  logic   bp_on;
  int     mismatches = 0;
  int     failures = 0;
  int     rx_count = 0;
  int     total_beats = 0;
  int     limit_cycles;

  accel_rd_subsys #(
    .DATA_WIDTH (DATA_WIDTH),
    .ADDR_WIDTH (ADDR_WIDTH),
    .LEN_WIDTH  (LEN_WIDTH),
    .FIFO_LINES (FIFO_LINES)
  ) i_accel_rd_subsys (
    .clk        (clk),
    .rst        (rst),
    .desc_addr  (desc_addr),
    .desc_len   (desc_len),
    .desc_valid (desc_valid),
    .desc_ready (desc_ready),
    .accel_stop (accel_stop),
    .wr_en      (wr_en),
    .wr_line    (wr_line),
    .wr_data    (wr_data),
    .m_tdata    (m_tdata),
    .m_tempty   (m_tempty),
    .m_tfirst   (m_tfirst),
    .m_tlast    (m_tlast),
    .m_tvalid   (m_tvalid),
    .m_tready   (m_tready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic compare_data(input string name, input logic [DATA_WIDTH-1:0] exp,
                              input logic [DATA_WIDTH-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic compare_empty(input string name, input logic [MASK_BITS-1:0] exp,
                               input logic [MASK_BITS-1:0] act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  // Beat k covers the bytes from addr + k * BYTES, wrapping at the memory top
  task automatic push_expected(input logic [ADDR_WIDTH-1:0] addr,
                               input logic [LEN_WIDTH-1:0] len);
    int                    beats;
    logic [ADDR_WIDTH-1:0] a;
    logic [DATA_WIDTH-1:0] data;
    logic [MASK_BITS-1:0]  empty;
    beats = (len + BYTES - 1) / BYTES;
    for (int k = 0; k < beats; k++) begin
      for (int i = 0; i < BYTES; i++) begin
        a = addr + ADDR_WIDTH'(k * BYTES + i);
        data[8*i +: 8] = mem_model[a];
      end
      empty = '0;
      if (k == beats - 1 && (len % BYTES) != 0) begin
        empty = MASK_BITS'(BYTES - len % BYTES);
      end
      exp_q.push_back({k == 0, k == beats - 1, empty, data});
    end
  endtask

  // Holds desc_valid until the descriptor is taken, returns on the accepting edge
  task automatic offer_desc(input logic [ADDR_WIDTH-1:0] addr,
                            input logic [LEN_WIDTH-1:0] len);
    desc_addr  <= addr;
    desc_len   <= len;
    desc_valid <= 1'b1;
    do begin
      @(negedge clk);
    end while (!desc_ready);
    @(posedge clk);
    push_expected(addr, len);
  endtask

  task automatic wait_drained(input int max_cycles);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < max_cycles) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      failures++;
      $display("Error at %0t: %0d expected beats never arrived", $time, exp_q.size());
      exp_q.delete();
    end
  endtask

  always @(posedge clk) begin
    if (bp_on) begin
      m_tready <= ($random(seed) & 3) != 0;
    end else begin
      m_tready <= 1'b1;
    end
  end

  // Both sides of the handshake are stable at the falling edge
  always @(negedge clk) begin
    if (!rst && m_tvalid && m_tready) begin
      rx_count++;
      if (exp_q.size() == 0) begin
        failures++;
        $display("Error at %0t: beat received with no beat expected", $time);
      end else begin
        exp_beat = exp_q.pop_front();
        compare_data("m_tdata", exp_beat[DATA_WIDTH-1:0], m_tdata);
        compare_empty("m_tempty", exp_beat[DATA_WIDTH +: MASK_BITS], m_tempty);
        compare_flag("m_tlast", exp_beat[BEAT_W-2], m_tlast);
        compare_flag("m_tfirst", exp_beat[BEAT_W-1], m_tfirst);
      end
    end
  end

  initial begin
    logic [DATA_WIDTH-1:0] line_data;
    int                    start;
    int                    n;
    int                    asrt_fails;
    rst        = 1'b1;
    desc_addr  = '0;
    desc_len   = '0;
    desc_valid = 1'b0;
    accel_stop = 1'b0;
    wr_en      = 1'b0;
    wr_line    = '0;
    wr_data    = '0;
    m_tready   = 1'b1;
    bp_on      = 1'b0;

    // 0 single beat, 1..12 unaligned with 12 wrapping, 13..20 back-pressure,
    // 21..26 back to back, 27 stopped, 28 after the stop
    for (int i = 0; i < NUM_DESC; i++) begin
      d_addr[i] = $random(seed);
      d_len[i]  = 9 + ($random(seed) & 255);
    end
    d_addr[0][MASK_BITS-1:0] = '0;
    d_len[0]  = 1 + ($random(seed) & (BYTES - 1));
    d_addr[12] = ADDR_WIDTH'(MEM_BYTES - 13);
    d_len[12]  = 77;
    d_len[27]  = 480;
    for (int i = 0; i < NUM_DESC; i++) begin
      total_beats += (d_len[i] + BYTES - 1) / BYTES;
    end
    limit_cycles = 20 * total_beats + LINES + 1500;

    fork
      begin
        repeat (limit_cycles) @(posedge clk);
        $display("Timeout: run did not finish within %0d cycles", limit_cycles);
        $display("*** FAILED ***");
        $finish;
      end
    join_none

    repeat (10) @(posedge clk);
    rst <= 1'b0;

    for (int l = 0; l < LINES; l++) begin
      for (int w = 0; w < DATA_WIDTH / 32; w++) begin
        line_data[32*w +: 32] = $random(seed);
      end
      for (int i = 0; i < BYTES; i++) begin
        mem_model[l * BYTES + i] = line_data[8*i +: 8];
      end
      wr_en   <= 1'b1;
      wr_line <= LINE_W'(l);
      wr_data <= line_data;
      @(posedge clk);
    end
    wr_en <= 1'b0;
    repeat (2) @(posedge clk);

    for (int i = 0; i < 13; i++) begin
      offer_desc(d_addr[i], d_len[i]);
      desc_valid <= 1'b0;
      wait_drained(1000);
    end

    bp_on <= 1'b1;
    for (int i = 13; i < 21; i++) begin
      offer_desc(d_addr[i], d_len[i]);
      desc_valid <= 1'b0;
      repeat (2) @(posedge clk);
    end
    wait_drained(4000);

    for (int i = 21; i < 27; i++) begin
      offer_desc(d_addr[i], d_len[i]);
    end
    desc_valid <= 1'b0;
    wait_drained(4000);

    bp_on <= 1'b0;
    start = rx_count;
    offer_desc(d_addr[27], d_len[27]);
    desc_valid <= 1'b0;
    while (rx_count < start + 6) begin
      @(posedge clk);
    end
    accel_stop <= 1'b1;
    @(posedge clk);
    accel_stop <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (m_tvalid && n < 10);
    if (m_tvalid) begin
      failures++;
      $display("Error at %0t: m_tvalid still high 10 cycles after the stop", $time);
    end
    if (!desc_ready) begin
      failures++;
      $display("Error at %0t: desc_ready low after the stop", $time);
    end
    // Beats after the stop point are abandoned
    exp_q.delete();
    repeat (3) @(posedge clk);
    offer_desc(d_addr[28], d_len[28]);
    desc_valid <= 1'b0;
    wait_drained(1000);

    repeat (5) @(posedge clk);
    asrt_fails = i_accel_rd_subsys.i_accel_rd_checker.fail_cnt;
    $display("Error counts: %0d mismatches, %0d other failures, %0d assertion failures",
             mismatches, failures, asrt_fails);
    if (mismatches + failures + asrt_fails == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* accel_rd_subsys.f */
common/dma_mem_pkg.sv
common/dma_ctrl_pkg.sv
common/bank_rd_if.sv
common/line_req_if.sv
hw/rd_dma/rd_desc_issuer.sv
hw/rd_dma/rd_line_aligner.sv
hw/rd_dma/rd_out_fifo.sv
hw/scratch_mem.sv
hw/accel_rd_subsys.sv
tb/accel_rd_checker.sv
tb/accel_rd_subsys_tb.sv

/* Bender.yml */
package:
  name: accel_rd_subsys

sources:
  - files:
      - common/dma_mem_pkg.sv
      - common/dma_ctrl_pkg.sv
      - common/bank_rd_if.sv
      - common/line_req_if.sv
      - hw/rd_dma/rd_desc_issuer.sv
      - hw/rd_dma/rd_line_aligner.sv
      - hw/rd_dma/rd_out_fifo.sv
      - hw/scratch_mem.sv
      - hw/accel_rd_subsys.sv
  - target: test
    files:
      - tb/accel_rd_checker.sv
      - tb/accel_rd_subsys_tb.sv
